//--- verilog/mult_config.svh
// multiplier configuration: operand, subword and shift widths
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand and result width, fixed by the integer ISA
`define MULT_WIDTH 32

// subword width used by the 16x16 multiplier
`define MULT_HALF 16

// width of the normalizing shift amount
`define MULT_IMM_W 5

// shift applied after the low partial products of the
// high-word sequence
`define MULT_MULH_SHIFT 16

`endif

//--- verilog/mult_pkg.sv
// multiplier types: operation encoding, widths, request and sequencer control
`default_nettype none

`include "mult_config.svh"

package mult_pkg;

  // widths that carry a meaning
  typedef logic [`MULT_WIDTH-1:0] word_t;
  typedef logic [`MULT_HALF-1:0]  half_t;
  typedef logic [`MULT_IMM_W-1:0] shamt_t;

  // operation select
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'd0,
    MUL_MSU32 = 3'd1,
    MUL_I     = 3'd2,
    MUL_IR    = 3'd3,
    MUL_H     = 3'd4,
    MUL_DOT8  = 3'd5,
    MUL_DOT16 = 3'd6
  } mult_op_e;

  // one multiply request, held stable until it is taken
  typedef struct packed {
    mult_op_e   op;
    // upper halves of A and B for the short ops
    logic       subword;
    // bit 0 A signed, bit 1 B signed
    logic [1:0] op_signed;
    shamt_t     imm;
    word_t      op_a;
    word_t      op_b;
    word_t      op_c;
  } mult_req_t;

  // per-step steering of the short multiplier during MULH
  typedef struct packed {
    logic       active;
    shamt_t     imm;
    // bit 0 upper half of A, bit 1 upper half of B
    logic [1:0] subword_sel;
    logic [1:0] signed_sel;
    logic       shift_arith;
    // bit 32 of the running partial sum
    logic       carry;
    // running partial sum from the previous step
    word_t      acc;
  } mulh_ctrl_t;

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

endpackage

`default_nettype wire

//--- verilog/mult_mulh_seq.sv
// high-word multiply sequencer: four partial products over one shared 16x16 MAC
`default_nettype none
`timescale 1ns/1ps

`include "mult_config.svh"

module mult_mulh_seq import mult_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable_i,
  input  mult_op_e   op_i,
  input  logic [1:0] op_signed_i,
  input  logic       ex_ready_i,
  input  logic       mac_carry_i,
  input  word_t      mac_result_i,
  output mulh_ctrl_t ctrl_o,
  output logic       ready_o,
  output logic       multicycle_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  logic        save_carry;
  logic        clear_carry;
  logic        save_acc;
  word_t       acc_q;

  //////////////////////////////
  // step control
  //////////////////////////////

  always_comb begin
    state_d            = state_q;
    ctrl_o.active      = 1'b1;
    ctrl_o.imm         = '0;
    ctrl_o.subword_sel = 2'b00;
    ctrl_o.signed_sel  = 2'b00;
    ctrl_o.shift_arith = 1'b0;
    ctrl_o.carry       = carry_q;
    ctrl_o.acc         = acc_q;
    ready_o            = 1'b0;
    multicycle_o       = 1'b0;
    save_carry         = 1'b0;
    clear_carry        = 1'b0;
    save_acc           = 1'b0;

    case (state_q)
      IDLE: begin
        // short unit follows the request directly
        ctrl_o.active = 1'b0;
        ready_o       = 1'b1;
        if (enable_i && (op_i == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // AL*BL unsigned, fresh sum, keep only the upper 16 bits
        multicycle_o = 1'b1;
        ctrl_o.imm   = shamt_t'(`MULT_MULH_SHIFT);
        ctrl_o.acc   = '0;
        save_acc     = 1'b1;
        state_d      = STEP1;
      end
      STEP1: begin
        // AL*BH takes B's sign; sum may need 33 bits
        multicycle_o       = 1'b1;
        ctrl_o.subword_sel = 2'b10;
        ctrl_o.signed_sel  = {op_signed_i[1], 1'b0};
        ctrl_o.shift_arith = 1'b1;
        save_carry         = 1'b1;
        save_acc           = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // AH*BL takes A's sign, then shift the 34-bit sum back down
        multicycle_o       = 1'b1;
        ctrl_o.subword_sel = 2'b01;
        ctrl_o.signed_sel  = {1'b0, op_signed_i[0]};
        ctrl_o.imm         = shamt_t'(`MULT_MULH_SHIFT);
        ctrl_o.shift_arith = 1'b1;
        // top bits are folded into the shift, carry not needed after
        save_carry         = 1'b1;
        clear_carry        = 1'b1;
        save_acc           = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // AH*BH with both signs, result valid until taken
        ctrl_o.subword_sel = 2'b11;
        ctrl_o.signed_sel  = op_signed_i;
        ready_o            = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (save_carry) begin
        carry_q <= ~clear_carry & mac_carry_i;
      end else if (ex_ready_i) begin
        // next instruction starts with a clean carry
        carry_q <= 1'b0;
      end
    end
  end

  // partial sum carried from one step to the next
  always_ff @(posedge clk) begin
    if (save_acc) begin
      acc_q <= mac_result_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mult_short_mac.sv
// 16x16 subword multiply-accumulate with rounding and normalizing shift
`default_nettype none
`timescale 1ns/1ps

`include "mult_config.svh"

module mult_short_mac import mult_pkg::*; (
  input  mult_req_t  req_i,
  input  mulh_ctrl_t ctrl_i,
  output word_t      result_o,
  output logic       mac_carry_o
);

  shamt_t      short_imm;
  logic [1:0]  short_subword;
  logic [1:0]  short_signed;
  logic        short_shift_arith;
  half_t       half_a;
  half_t       half_b;
  logic [16:0] short_op_a;
  logic [16:0] short_op_b;
  logic [32:0] short_op_c;
  logic [33:0] short_mul;
  word_t       round_tmp;
  word_t       short_round;
  logic [33:0] short_mac;
  logic        mac_msb1;
  logic        mac_msb0;
  logic [33:0] short_result;

  // sequencer steering wins while a MULH runs
  assign short_imm         = ctrl_i.active ? ctrl_i.imm : req_i.imm;
  assign short_subword     = ctrl_i.active ? ctrl_i.subword_sel : {2{req_i.subword}};
  assign short_signed      = ctrl_i.active ? ctrl_i.signed_sel : req_i.op_signed;
  // A unsigned with B signed is illegal here, so A's sign decides
  assign short_shift_arith = ctrl_i.active ? ctrl_i.shift_arith : req_i.op_signed[0];

  // half select and 17-bit sign extension
  assign half_a = short_subword[0] ? req_i.op_a[`MULT_WIDTH-1:`MULT_HALF]
                                   : req_i.op_a[`MULT_HALF-1:0];
  assign half_b = short_subword[1] ? req_i.op_b[`MULT_WIDTH-1:`MULT_HALF]
                                   : req_i.op_b[`MULT_HALF-1:0];
  assign short_op_a = {short_signed[0] & half_a[`MULT_HALF-1], half_a};
  assign short_op_b = {short_signed[1] & half_b[`MULT_HALF-1], half_b};

  // 17x17 signed product, computed on 34-bit extended operands
  assign short_mul = {{17{short_op_a[16]}}, short_op_a} * {{17{short_op_b[16]}}, short_op_b};

  // rounding adds half an lsb of the shifted result
  assign round_tmp   = word_t'(1) << req_i.imm;
  assign short_round = (req_i.op == MUL_IR) ? {1'b0, round_tmp[31:1]} : '0;

  // accumulator: partial sum plus saved carry during MULH, op_c otherwise
  assign short_op_c = ctrl_i.active ? {ctrl_i.carry, ctrl_i.acc}
                                    : {req_i.op_c[31], req_i.op_c};
  assign short_mac  = {short_op_c[32], short_op_c} + short_mul + {2'b00, short_round};

  // MULH keeps two extra sum bits for the step shift
  assign mac_msb1 = ctrl_i.active ? short_mac[33] : short_mac[31];
  assign mac_msb0 = ctrl_i.active ? short_mac[32] : short_mac[31];

  assign short_result = $signed({short_shift_arith & mac_msb1,
                                 short_shift_arith & mac_msb0,
                                 short_mac[31:0]}) >>> short_imm;

  assign result_o    = short_result[31:0];
  assign mac_carry_o = short_mac[32];

endmodule

`default_nettype wire

//--- verilog/mult_dot_unit.sv
// 8-bit and 16-bit dot products with accumulate on the A, B and C operands
`default_nettype none
`timescale 1ns/1ps

module mult_dot_unit import mult_pkg::*; (
  input  mult_req_t req_i,
  output word_t     dot8_o,
  output word_t     dot16_o
);

  word_t [3:0] byte_a;
  word_t [3:0] byte_b;
  word_t [3:0] byte_mul;
  word_t [1:0] half_a;
  word_t [1:0] half_b;
  word_t [1:0] half_mul;
  word_t       dot8_sum;
  word_t       dot16_sum;

  //////////////////////////////
  // byte lanes
  //////////////////////////////

  // each lane sign-extended to full width, products wrap mod 2^32
  always_comb begin
    dot8_sum = req_i.op_c;
    for (int i = 0; i < 4; i++) begin
      byte_a[i] = {{24{req_i.op_signed[0] & req_i.op_a[8*i+7]}}, req_i.op_a[8*i +: 8]};
      byte_b[i] = {{24{req_i.op_signed[1] & req_i.op_b[8*i+7]}}, req_i.op_b[8*i +: 8]};
      byte_mul[i] = byte_a[i] * byte_b[i];
      dot8_sum    = dot8_sum + byte_mul[i];
    end
  end

  //////////////////////////////
  // half-word lanes
  //////////////////////////////

  always_comb begin
    dot16_sum = req_i.op_c;
    for (int i = 0; i < 2; i++) begin
      half_a[i] = {{16{req_i.op_signed[0] & req_i.op_a[16*i+15]}}, req_i.op_a[16*i +: 16]};
      half_b[i] = {{16{req_i.op_signed[1] & req_i.op_b[16*i+15]}}, req_i.op_b[16*i +: 16]};
      // low 32 bits of the 17x17 product are all the result keeps
      half_mul[i] = half_a[i] * half_b[i];
      dot16_sum   = dot16_sum + half_mul[i];
    end
  end

  assign dot8_o  = dot8_sum;
  assign dot16_o = dot16_sum;

endmodule

`default_nettype wire

//--- verilog/mult_result_stage.sv
// 32-bit multiply-accumulate and multiply-subtract plus final result select
`default_nettype none
`timescale 1ns/1ps

module mult_result_stage import mult_pkg::*; (
  input  mult_req_t req_i,
  input  word_t     short_i,
  input  word_t     dot8_i,
  input  word_t     dot16_i,
  output word_t     result_o
);

  logic  is_msu;
  word_t op_a_msu;
  word_t op_b_msu;
  word_t mac32;

  //////////////////////////////
  // 32x32 MAC / MSU
  //////////////////////////////

  assign is_msu = (req_i.op == MUL_MSU32);

  // -A*B == ~A*B + B, so one multiplier serves both
  assign op_a_msu = req_i.op_a ^ {$bits(word_t){is_msu}};
  assign op_b_msu = req_i.op_b & {$bits(word_t){is_msu}};

  // only the low word is kept, so signedness does not matter
  assign mac32 = req_i.op_c + op_b_msu + op_a_msu * req_i.op_b;

  //////////////////////////////
  // output select
  //////////////////////////////

  always_comb begin
    case (req_i.op)
      MUL_MAC32, MUL_MSU32: result_o = mac32;
      MUL_I, MUL_IR, MUL_H: result_o = short_i;
      MUL_DOT8:             result_o = dot8_i;
      MUL_DOT16:            result_o = dot16_i;
      // unused encoding
      default:              result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mult_top.sv
// integer multiply unit top: sequencer, short MAC, dot unit and result stage
`default_nettype none
`timescale 1ns/1ps

module mult_top import mult_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  mulh_ctrl_t mulh_ctrl;
  word_t      short_result;
  logic       mac_carry;
  word_t      dot8_result;
  word_t      dot16_result;

  // MULH step control, also the accept/ready handshake
  mult_mulh_seq u_mulh_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .op_i         (req_i.op),
    .op_signed_i  (req_i.op_signed),
    .ex_ready_i   (ex_ready_i),
    .mac_carry_i  (mac_carry),
    .mac_result_i (short_result),
    .ctrl_o       (mulh_ctrl),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  // shared 16x16 MAC, MUL_I/MUL_IR and every MULH step
  mult_short_mac u_short_mac (
    .req_i       (req_i),
    .ctrl_i      (mulh_ctrl),
    .result_o    (short_result),
    .mac_carry_o (mac_carry)
  );

  mult_dot_unit u_dot_unit (
    .req_i   (req_i),
    .dot8_o  (dot8_result),
    .dot16_o (dot16_result)
  );

  // 32-bit MAC/MSU and the output mux
  mult_result_stage u_result_stage (
    .req_i    (req_i),
    .short_i  (short_result),
    .dot8_i   (dot8_result),
    .dot16_i  (dot16_result),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

//--- verification/mult_tb.sv
// directed testbench for the multiply unit covering MAC, subword, MULH and dot operations
`default_nettype none
`timescale 1ns/1ps

`include "mult_config.svh"

module mult_tb import mult_pkg::*; ();

  localparam int RESET_CYCLES    = 8;
  localparam int NUM_RANDOM      = 50;
  localparam int NUM_SHORT       = 40;
  // operations applied by the reset, mac, short, mulh, back-pressure and dot tests
  localparam int NUM_TESTS       = 1 + 2*NUM_RANDOM + 2*NUM_SHORT + 6 + 3 + 8;
  localparam int WATCHDOG_CYCLES = NUM_TESTS*20 + RESET_CYCLES;

  logic      clk;
  logic      rst_n;
  logic      enable;
  mult_req_t req;
  logic      ex_ready;
  word_t     result;
  logic      ready;
  logic      multicycle;
  int        errors;
  int        checks;

  mult_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable),
    .req_i        (req),
    .ex_ready_i   (ex_ready),
    .result_o     (result),
    .ready_o      (ready),
    .multicycle_o (multicycle)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////
  // reference models
  //////////////////////////////

  // low `bits` of value zero or sign extended to 64 bits
  function automatic logic [63:0] widen(input word_t value, input int bits, input logic is_signed);
    logic [63:0] mask;
    logic [63:0] v;
    mask = (64'd1 << bits) - 64'd1;
    v    = {32'b0, value} & mask;
    if (is_signed && v[bits-1]) begin
      v = v | ~mask;
    end
    return v;
  endfunction

  // subword product plus op_c and optional round then shift by imm
  function automatic word_t short_model(input mult_req_t r, input logic round);
    word_t       ha;
    word_t       hb;
    logic [63:0] prod;
    word_t       sum;
    ha   = r.subword ? (r.op_a >> `MULT_HALF) : r.op_a;
    hb   = r.subword ? (r.op_b >> `MULT_HALF) : r.op_b;
    prod = widen(ha, `MULT_HALF, r.op_signed[0]) * widen(hb, `MULT_HALF, r.op_signed[1]);
    sum  = r.op_c + prod[31:0];
    if (round && (r.imm != 0)) begin
      sum = sum + (word_t'(1) << (r.imm - 1));
    end
    // A's sign picks the shift kind
    if (r.op_signed[0]) begin
      return $signed(sum) >>> r.imm;
    end else begin
      return sum >> r.imm;
    end
  endfunction

  // upper word of the full 64-bit product
  function automatic word_t mulh_model(input word_t a, input word_t b, input logic [1:0] sgn);
    logic [63:0] prod;
    prod = widen(a, `MULT_WIDTH, sgn[0]) * widen(b, `MULT_WIDTH, sgn[1]);
    return prod[63:32];
  endfunction

  // op_c plus the sum of lane products wrapped to 32 bits
  function automatic word_t dot_model(input mult_req_t r, input int lane_bits);
    logic [63:0] acc;
    acc = {32'b0, r.op_c};
    for (int i = 0; i < `MULT_WIDTH/lane_bits; i++) begin
      acc = acc + widen(r.op_a >> (i*lane_bits), lane_bits, r.op_signed[0])
                * widen(r.op_b >> (i*lane_bits), lane_bits, r.op_signed[1]);
    end
    return acc[31:0];
  endfunction

  //////////////////////////////
  // checks and drivers
  //////////////////////////////

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  // new request on the falling edge and sampled once it has settled
  task automatic drive_request(input mult_req_t r);
    @(negedge clk);
    req      = r;
    enable   = 1'b1;
    ex_ready = 1'b1;
    #1;
  endtask

  task automatic reset_outputs();
    #1;
    check_bit("ready_o", ready, 1'b1);
    check_bit("multicycle_o", multicycle, 1'b0);
  endtask

  task automatic mac32_random();
    mult_req_t r;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r      = '0;
      r.op_a = $urandom();
      r.op_b = $urandom();
      r.op_c = $urandom();
      r.op   = MUL_MAC32;
      drive_request(r);
      check_word("result_o MAC32", result, r.op_c + r.op_a * r.op_b);
      r.op   = MUL_MSU32;
      drive_request(r);
      check_word("result_o MSU32", result, r.op_c - r.op_a * r.op_b);
    end
  endtask

  task automatic subword_random();
    mult_req_t r;
    int        sel;
    for (int i = 0; i < NUM_SHORT; i++) begin
      r           = '0;
      r.op_a      = $urandom();
      r.op_b      = $urandom();
      r.op_c      = $urandom();
      r.subword   = 1'($urandom() % 2);
      // A unsigned with B signed is not a legal short op
      sel         = int'($urandom() % 3);
      r.op_signed = (sel == 0) ? 2'b00 : (sel == 1) ? 2'b01 : 2'b11;
      // first vector covers the unshifted case
      r.imm       = (i == 0) ? shamt_t'(0) : shamt_t'($urandom() % 32);
      r.op        = MUL_I;
      drive_request(r);
      check_word("result_o MUL_I", result, short_model(r, 1'b0));
      r.op        = MUL_IR;
      drive_request(r);
      check_word("result_o MUL_IR", result, short_model(r, 1'b1));
    end
  endtask

  // one MULH with `stall` cycles of back-pressure once FINISH is reached
  task automatic run_mulh(input word_t a, input word_t b, input logic [1:0] sgn, input int stall);
    mult_req_t r;
    word_t     expected;
    int        cycles;
    int        busy;
    r           = '0;
    r.op        = MUL_H;
    r.op_signed = sgn;
    r.op_a      = a;
    r.op_b      = b;
    expected    = mulh_model(a, b, sgn);
    @(negedge clk);
    req      = r;
    enable   = 1'b1;
    ex_ready = (stall == 0);
    #1;
    check_bit("ready_o after accept", ready, 1'b0);
    check_bit("multicycle_o after accept", multicycle, 1'b0);
    cycles = 0;
    busy   = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (multicycle) begin
        busy++;
      end
    end while (!ready && (cycles < 10));
    checks++;
    if (!ready) begin
      $display("ERROR: MULH never raised ready_o within 10 cycles");
      errors++;
    end else if (cycles != 4) begin
      $display("ERROR: MULH raised ready_o after %0d cycles instead of 4", cycles);
      errors++;
    end
    checks++;
    if (busy != 3) begin
      $display("ERROR: multicycle_o was high for %0d cycles instead of 3", busy);
      errors++;
    end
    check_word("result_o MULH", result, expected);
    repeat (stall) begin
      @(negedge clk);
      check_bit("ready_o stalled", ready, 1'b1);
      check_word("result_o stalled", result, expected);
    end
    // result taken on the next rising edge
    enable   = 1'b0;
    ex_ready = 1'b1;
  endtask

  task automatic mulh_signs();
    run_mulh($urandom(), $urandom(), 2'b11, 0);
    run_mulh(32'h8000_0000, 32'hffff_ffff, 2'b11, 0);
    run_mulh($urandom(), $urandom(), 2'b01, 0);
    run_mulh(32'h8000_0000, 32'hffff_ffff, 2'b01, 0);
    run_mulh($urandom(), $urandom(), 2'b00, 0);
    run_mulh(32'hffff_ffff, 32'hffff_ffff, 2'b00, 0);
  endtask

  task automatic mulh_backpressure();
    mult_req_t r;
    run_mulh($urandom(), $urandom(), 2'b11, 5);
    r      = '0;
    r.op   = MUL_MAC32;
    r.op_a = $urandom();
    r.op_b = $urandom();
    r.op_c = $urandom();
    drive_request(r);
    check_word("result_o MAC32 after stall", result, r.op_c + r.op_a * r.op_b);
    // a stale carry would corrupt the next sequence
    run_mulh($urandom(), $urandom(), 2'b01, 0);
  endtask

  task automatic dot_signs();
    mult_req_t r;
    for (int s = 0; s < 4; s++) begin
      r           = '0;
      r.op_a      = $urandom();
      r.op_b      = $urandom();
      r.op_c      = $urandom();
      r.op_signed = 2'(s);
      r.op        = MUL_DOT8;
      drive_request(r);
      check_word("result_o DOT8", result, dot_model(r, 8));
      r.op        = MUL_DOT16;
      drive_request(r);
      check_word("result_o DOT16", result, dot_model(r, 16));
    end
  endtask

  initial begin
    errors   = 0;
    checks   = 0;
    rst_n    = 1'b0;
    enable   = 1'b0;
    ex_ready = 1'b1;
    req      = '0;
    void'($urandom(32'h83d7_0b25));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_outputs();
    mac32_random();
    subword_random();
    mulh_signs();
    mulh_backpressure();
    dot_signs();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/mult_pkg.sv
verilog/mult_mulh_seq.sv
verilog/mult_short_mac.sv
verilog/mult_dot_unit.sv
verilog/mult_result_stage.sv
verilog/mult_top.sv
verification/mult_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the multiply unit testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -sv -f project.f --top-module mult_tb -o mult_tb_sim \
  && ./obj_dir/mult_tb_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
  && exit 0 \
  || exit 1
